/* design/dual_decode.sv */
`timescale 1ns/100ps

module dual_decode import frontend_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,
    input  logic         hold,
    input  fetch_entry_t rd_entry_1,
    input  fetch_entry_t rd_entry_2,
    input  logic         rd_ok_1,
    input  logic         rd_ok_2,
    output logic         pop_1,
    output logic         pop_2,
    output logic         dec_valid_1,
    output logic         dec_valid_2,
    output decoded_t     dec_1,
    output decoded_t     dec_2
);

    function automatic inst_class_t op_class(input logic [6:0] opcode);
        case (opcode)
            OPC_LOAD:    op_class = CLS_LOAD;
            OPC_STORE:   op_class = CLS_STORE;
            OPC_BRANCH:  op_class = CLS_BRANCH;
            OPC_JAL:     op_class = CLS_JAL;
            OPC_ALU_IMM: op_class = CLS_ALU;
            OPC_ALU_REG: op_class = CLS_ALU;
            default:     op_class = CLS_OTHER;
        endcase
    endfunction

    // register fields are taken as is, whether the format uses them or not
    function automatic decoded_t decode(input fetch_entry_t e);
        decoded_t d;
        d.pc         = e.pc;
        d.cls        = op_class(e.instr[6:0]);
        d.rd         = e.instr[11:7];
        d.rs1        = e.instr[19:15];
        d.rs2        = e.instr[24:20];
        d.pred_taken = e.pred_taken;
        d.fault      = e.fault;
        return d;
    endfunction

    // rd_ok_2 only rises with rd_ok_1, so pop_2 never comes alone
    assign pop_1 = ~hold & rd_ok_1;
    assign pop_2 = ~hold & rd_ok_2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_1 <= 1'b0;
            dec_valid_2 <= 1'b0;
        end else if (flush) begin
            dec_valid_1 <= 1'b0;
            dec_valid_2 <= 1'b0;
        end else if (!hold) begin
            dec_valid_1 <= rd_ok_1;
            dec_valid_2 <= rd_ok_2;
        end
    end

    // while the back end holds, the records stay as they are
    always_ff @(posedge clk) begin
        if (!hold && rd_ok_1) begin
            dec_1 <= decode(rd_entry_1);
        end
        if (!hold && rd_ok_2) begin
            dec_2 <= decode(rd_entry_2);
        end
    end

endmodule

/* design/frontend_pkg.sv */
package frontend_pkg;

    // major opcodes that the front end looks at
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;

    // one instruction queue slot of 66 bits
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        pred_taken;
        logic        fault;
    } fetch_entry_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_OTHER
    } inst_class_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_class_t cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        pred_taken;
        logic        fault;
    } decoded_t;

endpackage

/* design/frontend_top.sv */
`timescale 1ns/100ps

module frontend_top import frontend_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic [31:0] imem_rdata_0,
    input  logic [31:0] imem_rdata_1,
    input  logic        hold,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    output logic        dec_valid_1,
    output logic        dec_valid_2,
    output decoded_t    dec_1,
    output decoded_t    dec_2
);

    fetch_entry_t wr_entry_1;
    fetch_entry_t wr_entry_2;
    fetch_entry_t rd_entry_1;
    fetch_entry_t rd_entry_2;
    logic         wr_en_1;
    logic         wr_en_2;
    logic         rd_ok_1;
    logic         rd_ok_2;
    logic         pop_1;
    logic         pop_2;
    logic         stall_req;

    inst_fetch i_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .stall_req    (stall_req),
        .imem_rdata_0 (imem_rdata_0),
        .imem_rdata_1 (imem_rdata_1),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .wr_en_1      (wr_en_1),
        .wr_en_2      (wr_en_2),
        .wr_entry_1   (wr_entry_1),
        .wr_entry_2   (wr_entry_2)
    );

    // a redirect empties the queue in the same cycle that fetch takes the new pc
    inst_queue i_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect),
        .pop_1      (pop_1),
        .pop_2      (pop_2),
        .wr_en_1    (wr_en_1),
        .wr_en_2    (wr_en_2),
        .wr_entry_1 (wr_entry_1),
        .wr_entry_2 (wr_entry_2),
        .rd_entry_1 (rd_entry_1),
        .rd_entry_2 (rd_entry_2),
        .rd_ok_1    (rd_ok_1),
        .rd_ok_2    (rd_ok_2),
        .stall_req  (stall_req)
    );

    dual_decode i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (redirect),
        .hold        (hold),
        .rd_entry_1  (rd_entry_1),
        .rd_entry_2  (rd_entry_2),
        .rd_ok_1     (rd_ok_1),
        .rd_ok_2     (rd_ok_2),
        .pop_1       (pop_1),
        .pop_2       (pop_2),
        .dec_valid_1 (dec_valid_1),
        .dec_valid_2 (dec_valid_2),
        .dec_1       (dec_1),
        .dec_2       (dec_2)
    );

endmodule

/* design/inst_fetch.sv */
`timescale 1ns/100ps
`include "frontend_params.svh"

module inst_fetch import frontend_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         redirect,
    input  logic [31:0]  redirect_pc,
    input  logic         stall_req,
    input  logic [31:0]  imem_rdata_0,
    input  logic [31:0]  imem_rdata_1,
    output logic         imem_req,
    output logic [31:0]  imem_addr,
    output logic         wr_en_1,
    output logic         wr_en_2,
    output fetch_entry_t wr_entry_1,
    output fetch_entry_t wr_entry_2
);

    logic [31:0] pc;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_nxt;
    logic        halted;
    logic        halt_nxt;
    logic        go;
    logic        fault_1;
    logic        fault_2;
    logic        jal_1;
    logic        jal_2;
    logic        single;

    // sign-extended J-type immediate
    function automatic logic [31:0] jal_offset(input logic [31:0] instr);
        jal_offset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

    assign imem_req  = ~halted;
    assign imem_addr = pc;
    assign pc_plus_4 = pc + 32'd4;

    assign go      = imem_req & ~stall_req & ~redirect;
    assign fault_1 = (pc >= `IMEM_LIMIT);
    assign fault_2 = (pc_plus_4 >= `IMEM_LIMIT);
    assign jal_1   = ~fault_1 & (imem_rdata_0[6:0] == OPC_JAL);
    assign jal_2   = ~fault_2 & (imem_rdata_1[6:0] == OPC_JAL);

    // slot 2 is skipped after an odd word pc, a predicted jal or a fault in slot 1
    assign single  = pc[2] | jal_1 | fault_1;

    assign wr_en_1 = go;
    assign wr_en_2 = go & ~single;

    // a faulted word carries no instruction bits
    always_comb begin
        wr_entry_1.pc         = pc;
        wr_entry_1.instr      = fault_1 ? 32'h0 : imem_rdata_0;
        wr_entry_1.pred_taken = jal_1;
        wr_entry_1.fault      = fault_1;

        wr_entry_2.pc         = pc_plus_4;
        wr_entry_2.instr      = fault_2 ? 32'h0 : imem_rdata_1;
        wr_entry_2.pred_taken = jal_2;
        wr_entry_2.fault      = fault_2;
    end

    always_comb begin
        pc_nxt   = pc;
        halt_nxt = halted;
        if (redirect) begin
            pc_nxt   = redirect_pc;
            halt_nxt = 1'b0;
        end else if (go) begin
            if (fault_1 || (!single && fault_2)) begin
                // stop requesting until the next redirect
                halt_nxt = 1'b1;
            end else if (jal_1) begin
                pc_nxt = pc + jal_offset(imem_rdata_0);
            end else if (pc[2]) begin
                pc_nxt = pc_plus_4;
            end else if (jal_2) begin
                pc_nxt = pc_plus_4 + jal_offset(imem_rdata_1);
            end else begin
                pc_nxt = pc + 32'd8;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else begin
            pc     <= pc_nxt;
            halted <= halt_nxt;
        end
    end

endmodule

/* design/inst_queue.sv */
`timescale 1ns/100ps
`include "frontend_params.svh"

module inst_queue import frontend_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,
    input  logic         pop_1,
    input  logic         pop_2,
    input  logic         wr_en_1,
    input  logic         wr_en_2,
    input  fetch_entry_t wr_entry_1,
    input  fetch_entry_t wr_entry_2,
    output fetch_entry_t rd_entry_1,
    output fetch_entry_t rd_entry_2,
    output logic         rd_ok_1,
    output logic         rd_ok_2,
    output logic         stall_req
);

    localparam int DEPTH = `IQ_DEPTH;
    localparam int IDX   = $clog2(DEPTH);

    typedef enum logic [1:0] {
        ST_NORMAL,
        ST_WAIT_1,
        ST_WAIT_2
    } q_state_t;

    q_state_t     state;
    q_state_t     state_nxt;

    fetch_entry_t mem [DEPTH];
    fetch_entry_t hold_1;
    fetch_entry_t hold_2;
    fetch_entry_t hold_1_nxt;
    fetch_entry_t hold_2_nxt;
    fetch_entry_t push_data_a;
    fetch_entry_t push_data_b;
    logic         push_a;
    logic         push_b;

    // pointers carry one extra wrap bit above the index
    logic [IDX:0] w_ptr;
    logic [IDX:0] r_ptr;
    logic [IDX:0] w_ptr_nxt;
    logic [IDX:0] r_ptr_nxt;
    logic [IDX:0] w_ptr_p1;
    logic [IDX:0] r_ptr_p1;
    logic         full;
    logic         empty;
    logic         left_one;

    assign w_ptr_p1 = w_ptr + 1'b1;
    assign r_ptr_p1 = r_ptr + 1'b1;

    assign empty    = (w_ptr == r_ptr);
    assign full     = (w_ptr[IDX] != r_ptr[IDX]) &&
                      (w_ptr[IDX-1:0] == r_ptr[IDX-1:0]);
    assign left_one = (w_ptr_p1[IDX] != r_ptr[IDX]) &&
                      (w_ptr_p1[IDX-1:0] == r_ptr[IDX-1:0]);

    assign rd_ok_1  = ~empty & ~flush;
    assign rd_ok_2  = ~empty & (r_ptr_p1 != w_ptr) & ~flush;

    // parked writes also hold off fetch until they are committed
    assign stall_req = (full | left_one | (state != ST_NORMAL)) & ~flush;

    assign rd_entry_1 = mem[r_ptr[IDX-1:0]];
    assign rd_entry_2 = mem[r_ptr_p1[IDX-1:0]];

    always_comb begin
        r_ptr_nxt = r_ptr;
        if (pop_1 && pop_2 && rd_ok_2) begin
            r_ptr_nxt = r_ptr + 2'd2;
        end else if (pop_1 && rd_ok_1) begin
            r_ptr_nxt = r_ptr_p1;
        end
    end

    always_comb begin
        state_nxt   = state;
        hold_1_nxt  = hold_1;
        hold_2_nxt  = hold_2;
        push_a      = 1'b0;
        push_b      = 1'b0;
        push_data_a = wr_entry_1;
        push_data_b = wr_entry_2;
        w_ptr_nxt   = w_ptr;

        case (state)
            ST_NORMAL: begin
                if (wr_en_1 && full) begin
                    hold_1_nxt = wr_entry_1;
                    if (wr_en_2) begin
                        hold_2_nxt = wr_entry_2;
                        state_nxt  = ST_WAIT_2;
                    end else begin
                        state_nxt  = ST_WAIT_1;
                    end
                end else if (wr_en_1 && wr_en_2 && left_one) begin
                    // the first word fits and the second one waits
                    push_a     = 1'b1;
                    hold_1_nxt = wr_entry_2;
                    state_nxt  = ST_WAIT_1;
                end else if (wr_en_1) begin
                    push_a = 1'b1;
                    push_b = wr_en_2;
                end
            end

            ST_WAIT_1: begin
                push_data_a = hold_1;
                if (!full) begin
                    push_a    = 1'b1;
                    state_nxt = ST_NORMAL;
                end
            end

            ST_WAIT_2: begin
                push_data_a = hold_1;
                push_data_b = hold_2;
                if (!full && !left_one) begin
                    push_a    = 1'b1;
                    push_b    = 1'b1;
                    state_nxt = ST_NORMAL;
                end else if (left_one) begin
                    // only one place free, so the older word goes first
                    push_a     = 1'b1;
                    hold_1_nxt = hold_2;
                    state_nxt  = ST_WAIT_1;
                end
            end

            default: begin
                state_nxt = ST_NORMAL;
            end
        endcase

        if (push_a) begin
            w_ptr_nxt = push_b ? w_ptr + 2'd2 : w_ptr_p1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_NORMAL;
            w_ptr <= '0;
            r_ptr <= '0;
        end else if (flush) begin
            state <= ST_NORMAL;
            w_ptr <= '0;
            r_ptr <= '0;
        end else begin
            state <= state_nxt;
            w_ptr <= w_ptr_nxt;
            r_ptr <= r_ptr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            hold_1 <= '0;
            hold_2 <= '0;
        end else begin
            hold_1 <= hold_1_nxt;
            hold_2 <= hold_2_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush && push_a) begin
            mem[w_ptr[IDX-1:0]] <= push_data_a;
        end
        if (!flush && push_b) begin
            mem[w_ptr_p1[IDX-1:0]] <= push_data_b;
        end
    end

endmodule

/* include/frontend_params.svh */
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// number of instruction queue entries as a power of two
`define IQ_DEPTH   8

// first pc fetched after reset
`define RESET_PC   32'h0000_0000

// fetches at or above this byte address are marked as faults
`define IMEM_LIMIT 32'h0000_0400

`endif

/* sim/frontend_tb.sv */
`timescale 1ns/100ps
`include "frontend_params.svh"

module frontend_tb
    import frontend_pkg::*;
();

    logic         clk;
    logic         rst_n;
    logic         redirect;
    logic [31:0]  redirect_pc;
    logic         hold;
    logic         imem_req;
    logic [31:0]  imem_addr;
    logic [31:0]  imem_addr_4;
    logic [31:0]  imem_rdata_0;
    logic [31:0]  imem_rdata_1;
    logic         dec_valid_1;
    logic         dec_valid_2;
    decoded_t     dec_1;
    decoded_t     dec_2;

    logic [31:0]  image [256];
    inst_class_t  img_cls [256];
    logic [31:0]  img_off [256];
    logic [31:0]  rng_state = 32'hd3ff;
    logic [31:0]  model_pc;
    logic         model_halted;
    int           error_count;
    int           n_checked;
    logic         timed_out;
    string        test_name;

    tb_clock i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    frontend_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_rdata_0 (imem_rdata_0),
        .imem_rdata_1 (imem_rdata_1),
        .hold         (hold),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .dec_valid_1  (dec_valid_1),
        .dec_valid_2  (dec_valid_2),
        .dec_1        (dec_1),
        .dec_2        (dec_2)
    );

    // the memory answers in the same cycle and faulted words are never looked at
    assign imem_addr_4  = imem_addr + 32'd4;
    assign imem_rdata_0 = image[imem_addr[9:2]];
    assign imem_rdata_1 = image[imem_addr_4[9:2]];

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic fill_image();
        logic [31:0] r;
        logic [31:0] bits;
        int          step;
        logic [6:0]  opc;
        for (int i = 0; i < 256; i++) begin
            r    = next_random();
            bits = next_random();
            // the last eight words hold no jal so that a walk from there reaches the limit
            if (r[3:0] == 4'd0 && i < 248) begin
                step       = (r[7:4] < 8) ? int'(r[7:4]) + 1 : 7 - int'(r[7:4]);
                img_off[i] = step * 4;
                img_cls[i] = CLS_JAL;
                image[i]   = jal_word(img_off[i][20:0], bits[11:7]);
            end else begin
                img_off[i] = 32'd4;
                case ((r >> 8) % 5)
                    0: begin
                        img_cls[i] = CLS_ALU;
                        opc        = r[4] ? 7'b0010011 : 7'b0110011;
                    end
                    1: begin
                        img_cls[i] = CLS_LOAD;
                        opc        = 7'b0000011;
                    end
                    2: begin
                        img_cls[i] = CLS_STORE;
                        opc        = 7'b0100011;
                    end
                    3: begin
                        img_cls[i] = CLS_BRANCH;
                        opc        = 7'b1100011;
                    end
                    default: begin
                        img_cls[i] = CLS_OTHER;
                        opc        = 7'b0110111;
                    end
                endcase
                image[i] = {bits[31:7], opc};
            end
        end
    endtask

    // walks the fetch rules one word at a time in program order
    task automatic model_next(output decoded_t d);
        logic [7:0] idx;
        d    = '0;
        d.pc = model_pc;
        if (model_pc >= `IMEM_LIMIT) begin
            d.cls        = CLS_OTHER;
            d.fault      = 1'b1;
            model_halted = 1'b1;
        end else begin
            idx          = model_pc[9:2];
            d.cls        = img_cls[idx];
            d.rd         = image[idx][11:7];
            d.rs1        = image[idx][19:15];
            d.rs2        = image[idx][24:20];
            d.pred_taken = (img_cls[idx] == CLS_JAL);
            model_pc     = model_pc + img_off[idx];
        end
    endtask

    task automatic check_decoded(input decoded_t exp, input decoded_t act);
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s: expected pc=%h cls=%0d %h, actual pc=%h cls=%0d %h",
                     test_name, exp.pc, exp.cls, exp,
                     act.pc, act.cls, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic take_record(input decoded_t act);
        decoded_t exp;
        if (model_halted) begin
            error_count++;
            $display("%s: a record at pc %h came out after the fault record",
                     test_name, act.pc);
        end else begin
            model_next(exp);
            check_decoded(exp, act);
            n_checked++;
        end
    endtask

    // a record leaves decode at an edge where hold is low and no redirect flushes it
    always @(negedge clk) begin
        if (rst_n && !hold && !redirect) begin
            if (dec_valid_1) begin
                take_record(dec_1);
            end
            if (dec_valid_2) begin
                take_record(dec_2);
            end
        end
    end

    task automatic wait_records(input int n, input int limit);
        int start;
        int cycles;
        start  = n_checked;
        cycles = 0;
        while (n_checked - start < n && !model_halted && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (n_checked - start < n && !model_halted) begin
            error_count++;
            timed_out = 1'b1;
            $display("%s: no progress on decoded records within %0d cycles", test_name, limit);
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(posedge clk);
        redirect     <= 1'b1;
        redirect_pc  <= pc;
        model_pc     = pc;
        model_halted = 1'b0;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    // hold comes in runs of random length and is high about three cycles in four
    task automatic drive_hold_random(input int cycles);
        logic [31:0] r;
        int          run;
        run = 0;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            if (run == 0) begin
                r    = next_random();
                hold <= (r[1:0] != 2'b00);
                run  = 1 + int'(r[9:4]);
            end
            run--;
        end
        @(posedge clk);
        hold <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          cycles;
        redirect     = 1'b0;
        redirect_pc  = 32'h0;
        hold         = 1'b0;
        error_count  = 0;
        n_checked    = 0;
        timed_out    = 1'b0;
        model_pc     = `RESET_PC;
        model_halted = 1'b0;
        fill_image();

        test_name = "reset";
        @(posedge clk);
        @(negedge clk);
        check_flag("imem_req", 1'b1, imem_req);
        check_addr("imem_addr", `RESET_PC, imem_addr);
        check_flag("dec_valid_1", 1'b0, dec_valid_1);
        check_flag("dec_valid_2", 1'b0, dec_valid_2);
        cycles = 0;
        while (!rst_n && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            error_count++;
            timed_out = 1'b1;
            $display("reset was never released");
        end

        test_name = "in-order stream";
        if (!timed_out) begin
            wait_records(80, 1000);
        end

        test_name = "back-pressure";
        if (!timed_out) begin
            r = next_random();
            redirect_to({23'd0, r[8:2], 2'b00});
            drive_hold_random(600);
            wait_records(60, 2000);
        end

        test_name = "redirect";
        for (int k = 0; k < 8 && !timed_out; k++) begin
            r = next_random();
            drive_hold_random(5 + int'(r[4:0]));
            r = next_random();
            redirect_to({22'd0, r[9:2], 2'b00});
        end
        if (!timed_out) begin
            wait_records(20, 1000);
        end

        test_name = "alignment";
        if (!timed_out) begin
            redirect_to(32'h0000_0104);
            wait_records(12, 500);
        end

        test_name = "fault";
        if (!timed_out) begin
            redirect_to(`IMEM_LIMIT - 32'd20);
            wait_records(1000, 500);
            if (!model_halted && !timed_out) begin
                error_count++;
                $display("fault: the fault record never came out");
            end
            repeat (30) @(posedge clk);
            @(negedge clk);
            check_flag("imem_req", 1'b0, imem_req);
        end

        $display("records checked %0d, errors %0d", n_checked, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb.f */
+incdir+include
design/frontend_pkg.sv
design/inst_fetch.sv
design/inst_queue.sv
design/dual_decode.sv
design/frontend_top.sv
sim/tb_clock.sv
sim/frontend_tb.sv
